// File: project.f
verilog/nmr_pkg.sv
verilog/nmr_param_regs.sv
verilog/cpmg_sequencer.sv
verilog/iq_downconverter.sv
verilog/echo_sample_packer.sv
verilog/nmr_pulse_programmer.sv
testbench/tb_nmr_checker.sv
testbench/tb_nmr.sv

// File: Makefile
.PHONY: all run clean

all: run

obj_dir/Vtb_nmr: project.f verilog/*.sv testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_nmr -f project.f

run: obj_dir/Vtb_nmr
	obj_dir/Vtb_nmr | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_nmr.sv
`timescale 1ns/1ps

module tb_nmr;
	import nmr_pkg::*;

	localparam int ECHO_IDX_W   = 8;
	localparam int SAMPLE_IDX_W = 10;
	localparam int N_SCANS      = 3;

	// columns follow the word addresses 2 to 9
	// p90, p180, d_nosig, d_sig, init_dly, samples, echoes, dc_sub
	localparam dur_t SCAN_SET [N_SCANS][8] = '{
		'{32'd3, 32'd5, 32'd4, 32'd3, 32'd2, 32'd6, 32'd3, 32'h0001_2345},
		'{32'd4, 32'd6, 32'd2, 32'd2, 32'd3, 32'd8, 32'd2, 32'hffff_0010},
		'{32'd1, 32'd0, 32'd1, 32'd0, 32'd1, 32'd1, 32'd4, 32'h0000_3fff}	// zero counts
	};
	localparam logic SCAN_PHASE [N_SCANS] = '{1'b0, 1'b1, 1'b0};

	logic        pulseprog_clk = 1'b0;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	wb_adr_t     wb_adr;
	wb_dat_t     wb_dat_w;
	wb_dat_t     wb_dat_r;
	logic        wb_ack;
	adc_raw_t    adc_data;
	logic        rf_out_p;
	logic        rf_out_n;
	logic        tx_gate;
	logic        en_rx;
	logic        busy;
	logic        sample_valid;
	iq_t         sample_i;
	iq_t         sample_q;
	logic [ECHO_IDX_W-1:0]   sample_echo;
	logic [SAMPLE_IDX_W-1:0] sample_idx;
	logic        run_done;	// all scans over, checker closes the books
	int          error_count;
	int          check_count;
	logic [31:0] lcg_state = 32'h474f5c33;
	int          cycle_cnt = 0;
	int          cycle_limit;	// sum of scan lengths plus bus overhead

	nmr_pulse_programmer #(
		.ECHO_IDX_W   (ECHO_IDX_W),
		.SAMPLE_IDX_W (SAMPLE_IDX_W)
	) dut_i (.*);

	tb_nmr_checker #(
		.ECHO_IDX_W   (ECHO_IDX_W),
		.SAMPLE_IDX_W (SAMPLE_IDX_W)
	) chk_i (.*);

	always #50 pulseprog_clk = ~pulseprog_clk;	// 100 ns period

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// busy length of scan s, zero lengths count as one
	function automatic int busy_cycles(input int s);
		int len [8];
		for (int j = 0; j < 8; j++)
			len[j] = (SCAN_SET[s][j] == '0) ? 1 : int'(SCAN_SET[s][j]);
		return len[0] + len[2] + len[6] * (len[1] + len[4] + len[5] + len[3]);
	endfunction

	// ====================
	// stimulus
	// ====================
	always @(posedge pulseprog_clk)
	begin
		#5;
		lcg_state = next_random(lcg_state);
		adc_data  = adc_raw_t'(lcg_state[31:18]);	// top bits, longest period
	end

	always @(posedge pulseprog_clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("timeout: scans still running after %0d cycles", cycle_cnt);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic step(input int n);
		repeat (n)
		begin
			@(posedge pulseprog_clk);
			#5;	// drive point
		end
	endtask

	task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		step(1);
		while (!wb_ack)
			step(1);	// ack due on the first edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		step(1);	// one idle cycle between accesses
	endtask

	task automatic write_reg(input wb_adr_t adr, input wb_dat_t dat);
		bus_access(1'b1, adr, dat);
	endtask

	task automatic read_reg(input wb_adr_t adr);
		bus_access(1'b0, adr, '0);	// checker compares the data
	endtask

	task automatic run_scan(input int s);
		for (int j = 0; j < 8; j++)
			write_reg(wb_adr_t'(int'(REG_P90) + j), SCAN_SET[s][j]);
		for (int j = 0; j < 8; j++)
			read_reg(wb_adr_t'(int'(REG_P90) + j));
		write_reg(REG_CTRL, {30'd0, SCAN_PHASE[s], 1'b1});	// phase and start together
		write_reg(REG_P90, SCAN_SET[s][0] + 32'd7);	// scan running, must not land
		read_reg(REG_STATUS);
		read_reg(REG_P90);
		read_reg(REG_CTRL);
		while (busy)
			step(1);
		step(4);	// let the last samples drain
	endtask

	// ====================
	// main sequence
	// ====================
	initial
	begin
		reset       = 1'b1;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		adc_data    = '0;
		run_done    = 1'b0;
		cycle_limit = 200;
		for (int s = 0; s < N_SCANS; s++)
			cycle_limit += busy_cycles(s);
		repeat (10) @(posedge pulseprog_clk);
		#5;
		reset = 1'b0;
		for (int s = 0; s < N_SCANS; s++)
			run_scan(s);
		run_done = 1'b1;
		step(2);
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: testbench/tb_nmr_checker.sv
`timescale 1ns/1ps

module tb_nmr_checker #(
	parameter int ECHO_IDX_W   = 8,
	parameter int SAMPLE_IDX_W = 10
) (
	input  logic                    pulseprog_clk,
	input  logic                    reset,
	input  logic                    run_done,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  nmr_pkg::wb_adr_t        wb_adr,
	input  nmr_pkg::wb_dat_t        wb_dat_w,
	input  nmr_pkg::wb_dat_t        wb_dat_r,
	input  logic                    wb_ack,
	input  nmr_pkg::adc_raw_t       adc_data,
	input  logic                    rf_out_p,
	input  logic                    rf_out_n,
	input  logic                    tx_gate,
	input  logic                    en_rx,
	input  logic                    busy,
	input  logic                    sample_valid,
	input  nmr_pkg::iq_t            sample_i,
	input  nmr_pkg::iq_t            sample_q,
	input  logic [ECHO_IDX_W-1:0]   sample_echo,
	input  logic [SAMPLE_IDX_W-1:0] sample_idx,
	output int                      error_count,
	output int                      check_count
);
	import nmr_pkg::*;

	dur_t    regs [16];	// shadow register map, by word address
	logic    phase;
	logic    busy_exp;	// expected busy this cycle
	logic    ack_exp;	// ack due at this negedge
	logic    rd_pending;
	wb_dat_t rd_exp;
	int      start_age;	// negedges since start write, -1 none
	int      busy_left;	// busy cycles still due
	logic    busy_q;
	logic    tx_q;
	logic    rx_q;
	logic    rf_q;	// expected carrier last cycle
	logic    done_q;
	int      tx_run;
	int      rx_run;
	int      tx_idx;	// pulses finished this scan
	int      rx_idx;	// rx windows finished, echo tag
	int      lo_cnt;	// busy cycles so far, lo phase
	int      exp_total;
	int      got_total;
	logic    hv [3];	// 3 cycle history of expected samples
	wb_dat_t hiq [3];
	int      he [3];
	int      hx [3];

	// programmed length, zero runs one cycle
	function automatic int seg_len(input wb_adr_t adr);
		return (regs[adr] == '0) ? 1 : int'(regs[adr]);
	endfunction

	function automatic int scan_len();
		return seg_len(REG_P90) + seg_len(REG_D_NOSIG) + seg_len(REG_ECHOES) *
			(seg_len(REG_P180) + seg_len(REG_INIT_DLY) + seg_len(REG_SAMPLES) + seg_len(REG_D_SIG));
	endfunction

	function automatic wb_dat_t read_value(input wb_adr_t adr);
		if (adr == REG_CTRL)
			return {30'd0, phase, 1'b0};	// start bit never reads back
		else if (adr == REG_STATUS)
			return {31'd0, busy_exp};
		else if (adr <= REG_DC_SUB)
			return regs[adr];
		else
			return '0;
	endfunction

	// {i, q} for one adc code at lo phase ph
	function automatic wb_dat_t mix_ref(input adc_raw_t adc, input dur_t dc, input int ph);
		iq_t d;
		d = iq_t'({2'b00, adc}) - iq_t'({2'b00, dc[ADC_PHYS_WIDTH-1:0]});
		case (ph % 4)
			0:       return {d, 16'h0000};
			1:       return {16'h0000, d};
			2:       return {-d, 16'h0000};
			default: return {16'h0000, -d};
		endcase
	endfunction

	task automatic compare(input string name, input wb_dat_t exp, input wb_dat_t got);
		check_count++;
		if (exp !== got)
		begin
			error_count++;
			$display("ERROR at %0d ns: %s expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	always @(negedge pulseprog_clk)
	begin
		logic    req;
		logic    acq;
		logic    rf_exp;
		int      pos;
		int      ini;
		int      smp;
		wb_dat_t iq_now;
		if (reset)
		begin
			for (int k = 0; k < 16; k++)
				regs[k] = '0;
			for (int k = 0; k < 3; k++)
				hv[k] = 1'b0;
			{phase, busy_exp, ack_exp, rd_pending, busy_q, tx_q, rx_q, rf_q, done_q} = '0;
			rd_exp      = '0;
			start_age   = -1;
			busy_left   = 0;
			tx_run      = 0;
			rx_run      = 0;
			tx_idx      = 0;
			rx_idx      = 0;
			lo_cnt      = 0;
			exp_total   = 0;
			got_total   = 0;
			error_count = 0;
			check_count = 0;
		end
		else
		begin
			// ====================
			// expected busy
			// ====================
			if (start_age >= 0)
				start_age++;
			if (start_age == 2)	// busy rises on the edge after the start pulse
			begin
				start_age = -1;
				busy_left = scan_len();
				tx_idx    = 0;
				rx_idx    = 0;
				lo_cnt    = 0;
				exp_total += seg_len(REG_ECHOES) * seg_len(REG_SAMPLES);
			end
			busy_exp = (busy_left > 0);
			if (busy_exp)
				busy_left--;
			compare("busy", 32'(busy_exp), 32'(busy));

			// ====================
			// wishbone
			// ====================
			req = wb_cyc & wb_stb & ~wb_ack;
			compare("wb_ack", 32'(ack_exp), 32'(wb_ack));
			if (wb_ack && rd_pending)
				compare("wb_dat_r", rd_exp, wb_dat_r);
			ack_exp    = req;
			rd_pending = req & ~wb_we;
			if (req && !wb_we)
				rd_exp = read_value(wb_adr);
			if (req && wb_we && !busy_exp)	// writes land only while idle
			begin
				if (wb_adr == REG_CTRL)
				begin
					phase = wb_dat_w[1];
					if (wb_dat_w[0])
						start_age = 0;
				end
				else if (wb_adr != REG_STATUS)
					regs[wb_adr] = wb_dat_w;
			end

			// ====================
			// pulse train
			// ====================
			if (!tx_gate)
				rf_exp = 1'b0;
			else if (!tx_q)
				rf_exp = (tx_idx == 0) ? ~phase : 1'b1;	// p180 always starts high
			else
				rf_exp = ~rf_q;
			compare("rf_out_p", 32'(rf_exp), 32'(rf_out_p));
			compare("rf_out_n", 32'(tx_gate & ~rf_exp), 32'(rf_out_n));
			if (tx_gate)
				tx_run = tx_q ? tx_run + 1 : 1;
			if (!tx_gate && tx_q)
			begin
				compare("tx_gate run", 32'(seg_len(tx_idx == 0 ? REG_P90 : REG_P180)),
					32'(tx_run));
				tx_idx++;
			end
			ini = seg_len(REG_INIT_DLY);
			smp = seg_len(REG_SAMPLES);
			pos = 0;
			if (en_rx)
			begin
				pos    = rx_q ? rx_run : 0;	// offset inside this rx window
				rx_run = pos + 1;
			end
			if (!en_rx && rx_q)
			begin
				compare("en_rx run", 32'(ini + smp + seg_len(REG_D_SIG)), 32'(rx_run));
				rx_idx++;
			end
			if (!busy && busy_q)
			begin
				compare("tx_gate pulses", 32'(1 + seg_len(REG_ECHOES)), 32'(tx_idx));
				compare("en_rx windows", 32'(seg_len(REG_ECHOES)), 32'(rx_idx));
			end

			// ====================
			// sample stream
			// ====================
			acq    = en_rx && (pos >= ini) && (pos < ini + smp);
			iq_now = mix_ref(adc_data, regs[REG_DC_SUB], lo_cnt);
			if (busy_exp)
				lo_cnt++;
			compare("sample_valid", 32'(hv[2]), 32'(sample_valid));
			if (hv[2] && sample_valid)
			begin
				compare("sample_i", {16'h0000, hiq[2][31:16]}, {16'h0000, sample_i});
				compare("sample_q", {16'h0000, hiq[2][15:0]}, {16'h0000, sample_q});
				compare("sample_echo", 32'(he[2]), 32'(sample_echo));
				compare("sample_idx", 32'(hx[2]), 32'(sample_idx));
			end
			if (sample_valid)
				got_total++;
			for (int k = 2; k > 0; k--)
			begin
				hv[k]  = hv[k-1];
				hiq[k] = hiq[k-1];
				he[k]  = he[k-1];
				hx[k]  = hx[k-1];
			end
			hv[0]  = acq;
			hiq[0] = iq_now;
			he[0]  = rx_idx;
			hx[0]  = pos - ini;
			if (run_done && !done_q)
				compare("valid sample count", 32'(exp_total), 32'(got_total));
			busy_q = busy;
			tx_q   = tx_gate;
			rx_q   = en_rx;
			rf_q   = rf_exp;
			done_q = run_done;
		end
	end

endmodule

// File: verilog/nmr_pulse_programmer.sv
`timescale 1ns/1ps

module nmr_pulse_programmer #(
	parameter int ECHO_IDX_W   = 8,
	parameter int SAMPLE_IDX_W = 10
) (
	input  logic                    pulseprog_clk,
	input  logic                    reset,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  nmr_pkg::wb_adr_t        wb_adr,
	input  nmr_pkg::wb_dat_t        wb_dat_w,
	output nmr_pkg::wb_dat_t        wb_dat_r,
	output logic                    wb_ack,
	input  nmr_pkg::adc_raw_t       adc_data,
	output logic                    rf_out_p,
	output logic                    rf_out_n,
	output logic                    tx_gate,
	output logic                    en_rx,
	output logic                    busy,
	output logic                    sample_valid,
	output nmr_pkg::iq_t            sample_i,
	output nmr_pkg::iq_t            sample_q,
	output logic [ECHO_IDX_W-1:0]   sample_echo,
	output logic [SAMPLE_IDX_W-1:0] sample_idx
);
	import nmr_pkg::*;

	logic start;	// one cycle scan start
	logic phase_cycle;	// 0 or 180 deg on p90
	dur_t p90;
	dur_t p180;
	dur_t d_nosig;
	dur_t d_sig;
	dur_t init_dly;
	dur_t samples;
	dur_t echoes;
	dur_t dc_sub;
	logic acq_window;	// sequencer acq segment
	iq_t  iq_i;
	iq_t  iq_q;

	// ====================
	// control path
	// ====================
	nmr_param_regs regs_i (
		.pulseprog_clk (pulseprog_clk),
		.reset         (reset),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack),
		.busy          (busy),
		.start         (start),
		.phase_cycle   (phase_cycle),
		.p90           (p90),
		.p180          (p180),
		.d_nosig       (d_nosig),
		.d_sig         (d_sig),
		.init_dly      (init_dly),
		.samples       (samples),
		.echoes        (echoes),
		.dc_sub        (dc_sub)
	);

	cpmg_sequencer seq_i (
		.pulseprog_clk (pulseprog_clk),
		.reset         (reset),
		.start         (start),
		.phase_cycle   (phase_cycle),
		.p90           (p90),
		.p180          (p180),
		.d_nosig       (d_nosig),
		.d_sig         (d_sig),
		.init_dly      (init_dly),
		.samples       (samples),
		.echoes        (echoes),
		.busy          (busy),
		.tx_gate       (tx_gate),
		.en_rx         (en_rx),
		.acq_window    (acq_window),
		.rf_out_p      (rf_out_p),
		.rf_out_n      (rf_out_n)
	);

	// ====================
	// receive path
	// ====================
	iq_downconverter dconv_i (
		.pulseprog_clk (pulseprog_clk),
		.reset         (reset),
		.busy          (busy),
		.adc_data      (adc_data),
		.dc_sub        (dc_sub),
		.iq_i          (iq_i),
		.iq_q          (iq_q)
	);

	echo_sample_packer #(
		.ECHO_IDX_W   (ECHO_IDX_W),
		.SAMPLE_IDX_W (SAMPLE_IDX_W)
	) pack_i (
		.pulseprog_clk (pulseprog_clk),
		.reset         (reset),
		.busy          (busy),
		.acq_window    (acq_window),
		.iq_i          (iq_i),
		.iq_q          (iq_q),
		.sample_valid  (sample_valid),
		.sample_i      (sample_i),
		.sample_q      (sample_q),
		.sample_echo   (sample_echo),
		.sample_idx    (sample_idx)
	);

endmodule

// File: verilog/echo_sample_packer.sv
`timescale 1ns/1ps

module echo_sample_packer #(
	parameter int ECHO_IDX_W   = 8,
	parameter int SAMPLE_IDX_W = 10
) (
	input  logic                    pulseprog_clk,
	input  logic                    reset,
	input  logic                    busy,
	input  logic                    acq_window,
	input  nmr_pkg::iq_t            iq_i,
	input  nmr_pkg::iq_t            iq_q,
	output logic                    sample_valid,
	output nmr_pkg::iq_t            sample_i,
	output nmr_pkg::iq_t            sample_q,
	output logic [ECHO_IDX_W-1:0]   sample_echo,
	output logic [SAMPLE_IDX_W-1:0] sample_idx
);

	logic [1:0] win_d;	// window, 2 cycles to meet the iq pipe
	logic [2:0] busy_d;	// busy at output timing

	// ====================
	// window and tags
	// ====================
	always_ff @(posedge pulseprog_clk)
	begin
		if (reset)
		begin
			win_d        <= 2'b00;
			busy_d       <= 3'b000;
			sample_valid <= 1'b0;
			sample_idx   <= '0;
			sample_echo  <= '0;
		end
		else
		begin
			win_d        <= {win_d[0], acq_window};
			busy_d       <= {busy_d[1:0], busy};
			sample_valid <= win_d[1];
			if (win_d[1])
				sample_idx <= sample_valid ? sample_idx + 1'b1 : '0;	// 0 at window start
			if (!busy_d[2])
				sample_echo <= '0;	// no scan
			else if (sample_valid && !win_d[1])
				sample_echo <= sample_echo + 1'b1;	// last sample of a window
		end
	end

	// iq payload, only inside the window
	always_ff @(posedge pulseprog_clk)
	begin
		if (win_d[1])
		begin
			sample_i <= iq_i;
			sample_q <= iq_q;
		end
	end

	// index restarts only on the first sample of a window
	idx_wrap_at_window: assert property (@(posedge pulseprog_clk) disable iff (reset)
		(sample_valid && sample_idx == '0) |-> !$past(sample_valid));

endmodule

// File: verilog/iq_downconverter.sv
`timescale 1ns/1ps

module iq_downconverter (
	input  logic             pulseprog_clk,
	input  logic             reset,
	input  logic             busy,
	input  nmr_pkg::adc_raw_t adc_data,
	input  nmr_pkg::dur_t    dc_sub,
	output nmr_pkg::iq_t     iq_i,
	output nmr_pkg::iq_t     iq_q
);
	import nmr_pkg::*;

	logic [1:0] lo_phase;	// quarter rate lo, 0 at first busy cycle
	logic [1:0] ph_d1;	// phase of the sample in stage 1
	iq_t        diff_d1;	// dc free sample

	always_ff @(posedge pulseprog_clk)
	begin
		if (reset)
			lo_phase <= 2'd0;
		else if (busy)
			lo_phase <= lo_phase + 2'd1;
		else
			lo_phase <= 2'd0;	// idle, restart lo
	end

	// ====================
	// stage 1, dc removal
	// ====================
	always_ff @(posedge pulseprog_clk)
	begin
		diff_d1 <= iq_t'(adc_data) - iq_t'(dc_sub[ADC_PHYS_WIDTH-1:0]);	// both zero extended
		ph_d1   <= lo_phase;
	end

	// ====================
	// stage 2, mixing
	// ====================
	always_ff @(posedge pulseprog_clk)
	begin
		case (ph_d1)
			2'd0:
			begin
				iq_i <= diff_d1;	// cos 0
				iq_q <= '0;
			end
			2'd1:
			begin
				iq_i <= '0;
				iq_q <= diff_d1;	// sin 90
			end
			2'd2:
			begin
				iq_i <= -diff_d1;	// cos 180
				iq_q <= '0;
			end
			default:
			begin
				iq_i <= '0;
				iq_q <= -diff_d1;	// sin 270
			end
		endcase
	end

endmodule

// File: verilog/cpmg_sequencer.sv
`timescale 1ns/1ps

module cpmg_sequencer (
	input  logic          pulseprog_clk,
	input  logic          reset,
	input  logic          start,
	input  logic          phase_cycle,
	input  nmr_pkg::dur_t p90,
	input  nmr_pkg::dur_t p180,
	input  nmr_pkg::dur_t d_nosig,
	input  nmr_pkg::dur_t d_sig,
	input  nmr_pkg::dur_t init_dly,
	input  nmr_pkg::dur_t samples,
	input  nmr_pkg::dur_t echoes,
	output logic          busy,
	output logic          tx_gate,
	output logic          en_rx,
	output logic          acq_window,
	output logic          rf_out_p,
	output logic          rf_out_n
);
	import nmr_pkg::*;

	seq_state_e state;	// current segment
	seq_state_e nxt_seg;	// segment after this one
	dur_t       dur_cnt;	// cycles left minus one
	dur_t       echo_cnt;	// echoes left after the current one
	dur_t       seg_dur;	// programmed length of nxt_seg
	logic       adv;	// leave current segment at this edge
	logic       rf_q;	// carrier, low outside tx

	// preset for the down counter, zero length runs one cycle
	function automatic dur_t load(input dur_t d);
		load = (d == '0) ? '0 : d - 1'b1;
	endfunction

	// ====================
	// segment order
	// ====================
	always_comb
	begin
		case (state)
			IDLE:    nxt_seg = P90;
			P90:     nxt_seg = D_NOSIG;
			D_NOSIG: nxt_seg = P180;
			P180:    nxt_seg = SETTLE;
			SETTLE:  nxt_seg = ACQ;
			ACQ:     nxt_seg = TAIL;
			default: nxt_seg = (echo_cnt == '0) ? IDLE : P180;	// tail, next echo or done
		endcase
	end

	always_comb
	begin
		case (nxt_seg)
			P90:     seg_dur = p90;
			D_NOSIG: seg_dur = d_nosig;
			P180:    seg_dur = p180;
			SETTLE:  seg_dur = init_dly;
			ACQ:     seg_dur = samples;
			TAIL:    seg_dur = d_sig;
			default: seg_dur = '0;
		endcase
	end

	assign adv = (state == IDLE) ? start : (dur_cnt == '0);

	// ====================
	// state and counters
	// ====================
	always_ff @(posedge pulseprog_clk)
	begin
		if (reset)
		begin
			state    <= IDLE;
			dur_cnt  <= '0;
			echo_cnt <= '0;
		end
		else if (adv)
		begin
			state   <= nxt_seg;
			dur_cnt <= load(seg_dur);
			if (state == IDLE)
				echo_cnt <= load(echoes);	// at least one echo
			else if (state == TAIL && nxt_seg == P180)
				echo_cnt <= echo_cnt - 1'b1;
		end
		else if (state != IDLE)
			dur_cnt <= dur_cnt - 1'b1;
	end

	// rf carrier, toggles every cycle inside a pulse
	always_ff @(posedge pulseprog_clk)
	begin
		if (reset)
			rf_q <= 1'b0;
		else if (adv)
			rf_q <= (nxt_seg == P90) ? ~phase_cycle : (nxt_seg == P180);	// p180 starts high
		else
			rf_q <= tx_gate & ~rf_q;
	end

	assign busy       = (state != IDLE);
	assign tx_gate    = (state == P90) || (state == P180);
	assign en_rx      = (state == SETTLE) || (state == ACQ) || (state == TAIL);
	assign acq_window = (state == ACQ);
	assign rf_out_p   = rf_q;
	assign rf_out_n   = tx_gate & ~rf_q;	// inverse only while gated

	tx_rx_exclusive: assert property (@(posedge pulseprog_clk) disable iff (reset)
		!(tx_gate && en_rx));

	acq_inside_rx: assert property (@(posedge pulseprog_clk) disable iff (reset)
		acq_window |-> en_rx);

endmodule

// File: verilog/nmr_param_regs.sv
`timescale 1ns/1ps

module nmr_param_regs (
	input  logic             pulseprog_clk,
	input  logic             reset,
	input  logic             wb_cyc,
	input  logic             wb_stb,
	input  logic             wb_we,
	input  nmr_pkg::wb_adr_t wb_adr,
	input  nmr_pkg::wb_dat_t wb_dat_w,
	output nmr_pkg::wb_dat_t wb_dat_r,
	output logic             wb_ack,
	input  logic             busy,
	output logic             start,
	output logic             phase_cycle,
	output nmr_pkg::dur_t    p90,
	output nmr_pkg::dur_t    p180,
	output nmr_pkg::dur_t    d_nosig,
	output nmr_pkg::dur_t    d_sig,
	output nmr_pkg::dur_t    init_dly,
	output nmr_pkg::dur_t    samples,
	output nmr_pkg::dur_t    echoes,
	output nmr_pkg::dur_t    dc_sub
);
	import nmr_pkg::*;

	logic    req;	// new bus cycle, ack not yet given
	logic    param_wr;	// write that may land
	wb_dat_t rd_data;	// read mux

	assign req      = wb_cyc & wb_stb & ~wb_ack;
	assign param_wr = req & wb_we & ~busy;	// scan running, drop the write

	// ====================
	// bus handshake
	// ====================
	always_ff @(posedge pulseprog_clk)
	begin
		if (reset)
		begin
			wb_ack   <= 1'b0;
			wb_dat_r <= '0;
			start    <= 1'b0;
		end
		else
		begin
			wb_ack <= req;	// one cycle, next edge
			if (req)
				wb_dat_r <= rd_data;	// held while ack high
			start <= param_wr && (wb_adr == REG_CTRL) && wb_dat_w[0];
		end
	end

	// ====================
	// parameter registers
	// ====================
	always_ff @(posedge pulseprog_clk)
	begin
		if (reset)
		begin
			phase_cycle <= 1'b0;
			p90         <= '0;
			p180        <= '0;
			d_nosig     <= '0;
			d_sig       <= '0;
			init_dly    <= '0;
			samples     <= '0;
			echoes      <= '0;
			dc_sub      <= '0;
		end
		else if (param_wr)
		begin
			case (wb_adr)
				REG_CTRL:     phase_cycle <= wb_dat_w[1];
				REG_P90:      p90         <= wb_dat_w;
				REG_P180:     p180        <= wb_dat_w;
				REG_D_NOSIG:  d_nosig     <= wb_dat_w;
				REG_D_SIG:    d_sig       <= wb_dat_w;
				REG_INIT_DLY: init_dly    <= wb_dat_w;
				REG_SAMPLES:  samples     <= wb_dat_w;
				REG_ECHOES:   echoes      <= wb_dat_w;
				REG_DC_SUB:   dc_sub      <= wb_dat_w;
				default:      ;	// status is read only
			endcase
		end
	end

	always_comb
	begin
		case (wb_adr)
			REG_CTRL:     rd_data = wb_dat_t'({phase_cycle, 1'b0});	// start reads 0
			REG_STATUS:   rd_data = wb_dat_t'(busy);
			REG_P90:      rd_data = p90;
			REG_P180:     rd_data = p180;
			REG_D_NOSIG:  rd_data = d_nosig;
			REG_D_SIG:    rd_data = d_sig;
			REG_INIT_DLY: rd_data = init_dly;
			REG_SAMPLES:  rd_data = samples;
			REG_ECHOES:   rd_data = echoes;
			REG_DC_SUB:   rd_data = dc_sub;
			default:      rd_data = '0;	// unmapped
		endcase
	end

	// ack drops after one cycle even with cyc/stb held
	ack_single_cycle: assert property (@(posedge pulseprog_clk) disable iff (reset)
		wb_ack |=> !wb_ack);

endmodule

// File: verilog/nmr_pkg.sv
package nmr_pkg;

	// ====================
	// widths
	// ====================
	localparam int ADC_PHYS_WIDTH = 14;	// adc code bits, no overflow bit
	localparam int DUR_WIDTH      = 32;	// durations and counts
	localparam int IQ_WIDTH       = 16;	// signed mixer output
	localparam int WB_ADR_WIDTH   = 4;	// word address
	localparam int WB_DAT_WIDTH   = 32;

	typedef logic [ADC_PHYS_WIDTH-1:0] adc_raw_t;	// unsigned adc code
	typedef logic signed [IQ_WIDTH-1:0] iq_t;	// one of i or q
	typedef logic [DUR_WIDTH-1:0] dur_t;	// pulseprog_clk cycles or a count
	typedef logic [WB_ADR_WIDTH-1:0] wb_adr_t;
	typedef logic [WB_DAT_WIDTH-1:0] wb_dat_t;

	// ====================
	// register map
	// ====================
	localparam wb_adr_t REG_CTRL     = 4'd0;	// bit0 start, bit1 phase
	localparam wb_adr_t REG_STATUS   = 4'd1;	// bit0 busy
	localparam wb_adr_t REG_P90      = 4'd2;	// 90 deg pulse length
	localparam wb_adr_t REG_P180     = 4'd3;	// 180 deg pulse length
	localparam wb_adr_t REG_D_NOSIG  = 4'd4;	// dead delay after p90
	localparam wb_adr_t REG_D_SIG    = 4'd5;	// tail after acq
	localparam wb_adr_t REG_INIT_DLY = 4'd6;	// rx settle before acq
	localparam wb_adr_t REG_SAMPLES  = 4'd7;	// samples per echo
	localparam wb_adr_t REG_ECHOES   = 4'd8;	// echoes per scan
	localparam wb_adr_t REG_DC_SUB   = 4'd9;	// adc dc offset

	// sequencer segments, in pulse train order
	typedef enum logic [2:0] {
		IDLE,
		P90,
		D_NOSIG,
		P180,
		SETTLE,
		ACQ,
		TAIL
	} seq_state_e;

endpackage
